//--- Bender.yml
package:
  name: axi_wr_demux

sources:
  - demux_pkg.sv
  - demux_id_table.sv
  - demux_w_route_fifo.sv
  - demux_aw_ctrl.sv
  - demux_b_arb.sv
  - demux_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_demux.sv

//--- demux_aw_ctrl.sv
/*
  AW admission with per-ID ordering and W steering by the route FIFO
  slv_aw_sel_i must be below NUM_PORTS and stable while AW valid is high
  once offered, the master AW valid is held until its ready
*/
`timescale 1ns/1ps

module demux_aw_ctrl
  import demux_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  // slave AW
  input  aw_chan_t                  slv_aw_i,
  input  sel_t                      slv_aw_sel_i,
  input  logic                      slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  // slave W
  input  w_chan_t                   slv_w_i,
  input  logic                      slv_w_valid_i,
  output logic                      slv_w_ready_o,
  // master AW
  output aw_chan_t [NUM_PORTS-1:0]  mst_aw_o,
  output logic     [NUM_PORTS-1:0]  mst_aw_valid_o,
  input  logic     [NUM_PORTS-1:0]  mst_aw_ready_i,
  // master W
  output w_chan_t  [NUM_PORTS-1:0]  mst_w_o,
  output logic     [NUM_PORTS-1:0]  mst_w_valid_o,
  input  logic     [NUM_PORTS-1:0]  mst_w_ready_i,
  // id table
  input  logic                      id_occupied_i,
  input  logic                      id_full_i,
  input  sel_t                      id_lookup_sel_i,
  // route FIFO
  input  logic                      fifo_full_i,
  input  logic                      fifo_empty_i,
  input  sel_t                      fifo_sel_i,
  // push into table and FIFO, pop of the FIFO
  output logic                      push_o,
  output logic                      fifo_pop_o
);

  aw_state_e state_q;
  aw_state_e state_d;

  logic admit;
  logic aw_valid;
  logic aw_ready;

  // room in both stores and no open write of this id at another port
  assign admit = !id_full_i && !fifo_full_i &&
                 (!id_occupied_i || (id_lookup_sel_i == slv_aw_sel_i));

  // ----------------------------------------
  // AW state machine
  // ----------------------------------------
  always_comb begin
    state_d        = state_q;
    aw_valid       = 1'b0;
    push_o         = 1'b0;
    slv_aw_ready_o = 1'b0;
    case (state_q)
      AW_IDLE: begin
        if (slv_aw_valid_i && admit) begin
          aw_valid = 1'b1;
          // push once, whether or not the master takes it now
          push_o   = 1'b1;
          if (aw_ready) begin
            slv_aw_ready_o = 1'b1;
          end else begin
            state_d = AW_LOCKED;
          end
        end
      end
      AW_LOCKED: begin
        // decision already pushed, only wait for the handshake
        aw_valid = 1'b1;
        if (aw_ready) begin
          slv_aw_ready_o = 1'b1;
          state_d        = AW_IDLE;
        end
      end
      default: state_d = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // master port steering
  // ----------------------------------------
  always_comb begin
    aw_ready      = 1'b0;
    slv_w_ready_o = 1'b0;
    fifo_pop_o    = 1'b0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      // AW goes only to the selected port
      mst_aw_o[i]       = slv_aw_i;
      mst_aw_valid_o[i] = 1'b0;
      if (aw_valid && (slv_aw_sel_i == sel_t'(i))) begin
        mst_aw_valid_o[i] = 1'b1;
        aw_ready          = mst_aw_ready_i[i];
      end
      // W follows the FIFO head, blocked while it is empty
      mst_w_o[i]       = slv_w_i;
      mst_w_valid_o[i] = 1'b0;
      if (!fifo_empty_i && (fifo_sel_i == sel_t'(i))) begin
        mst_w_valid_o[i] = slv_w_valid_i;
        slv_w_ready_o    = mst_w_ready_i[i];
        // burst done, next head steers the following beats
        fifo_pop_o       = slv_w_valid_i && mst_w_ready_i[i] && slv_w_i.last;
      end
    end
  end

  // offered AW holds valid and payload until the master takes it
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_aw_hold
    assert property (@(posedge clk_i) disable iff (rst_i)
      (mst_aw_valid_o[i] && !mst_aw_ready_i[i]) |=>
      (mst_aw_valid_o[i] && $stable(mst_aw_o[i])))
      else $error("aw valid dropped or changed on port %0d, aw %h", i, mst_aw_o[i]);
  end

endmodule

//--- demux_b_arb.sv
/*
  round-robin merge of the master B channels onto the slave port
  a grant stalled by slv_b_ready_i is locked until it transfers
  masters must hold B valid until ready
*/
`timescale 1ns/1ps

module demux_b_arb
  import demux_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  // master side requesters
  input  b_chan_t [NUM_PORTS-1:0]  mst_b_i,
  input  logic    [NUM_PORTS-1:0]  mst_b_valid_i,
  output logic    [NUM_PORTS-1:0]  mst_b_ready_o,
  // merged slave B
  output b_chan_t                  slv_b_o,
  output logic                     slv_b_valid_o,
  input  logic                     slv_b_ready_i
);

  // priority start, or the locked winner while lock_q is set
  sel_t rr_q;
  logic lock_q;

  sel_t gnt_idx;
  sel_t rr_next;
  logic found;
  logic gnt_valid;

  // ----------------------------------------
  // grant search
  // ----------------------------------------
  always_comb begin : arb_search
    int unsigned idx;
    idx     = 0;
    gnt_idx = rr_q;
    found   = 1'b0;
    // first valid port at or after the pointer
    if (!lock_q) begin
      for (int unsigned k = 0; k < NUM_PORTS; k++) begin
        idx = (rr_q + k) % NUM_PORTS;
        if (!found && mst_b_valid_i[idx]) begin
          found   = 1'b1;
          gnt_idx = sel_t'(idx);
        end
      end
    end
  end

  assign gnt_valid = lock_q ? mst_b_valid_i[rr_q] : found;

  // pointer moves one past the winner
  assign rr_next = (gnt_idx == sel_t'(NUM_PORTS - 1)) ? '0 : gnt_idx + sel_t'(1);

  assign slv_b_o       = mst_b_i[gnt_idx];
  assign slv_b_valid_o = gnt_valid;

  always_comb begin
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      mst_b_ready_o[i] = gnt_valid && slv_b_ready_i && (gnt_idx == sel_t'(i));
    end
  end

  // ----------------------------------------
  // pointer and lock
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else if (gnt_valid && slv_b_ready_i) begin
      rr_q   <= rr_next;
      lock_q <= 1'b0;
    end else if (gnt_valid) begin
      // stalled, keep this winner
      rr_q   <= gnt_idx;
      lock_q <= 1'b1;
    end
  end

  // a locked master must still be offering its response
  assert property (@(posedge clk_i) disable iff (rst_i) lock_q |-> mst_b_valid_i[rr_q])
    else $error("b valid withdrawn on locked port %h", rr_q);

endmodule

//--- demux_golden.txt
# one write per line, all hex: id sel len seed expected_port
# len is beats minus one, B resp is expected to equal the port
1 0 0 10 0
2 1 3 20 1
3 2 1 30 2
5 2 0 40 2
6 1 2 50 1
0 0 7 60 0
4 0 1 70 0
8 0 0 78 0
c 0 2 80 0
9 1 0 88 1
7 2 f 90 2
b 1 1 a0 1
a 2 0 b0 2
d 1 4 c0 1
e 0 2 d0 0
f 2 3 e0 2
0 1 0 f0 1
3 0 5 11 0
4 2 1 21 2
1 1 2 31 1

//--- demux_id_table.sv
/*
  per-ID count of open writes plus the port the ID went to
  push and pop of the same ID in one cycle leave the count unchanged
  full_o rises as soon as any counter holds MAX_TRANS
*/
`timescale 1ns/1ps

module demux_id_table
  import demux_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  // lookup of the AW waiting at the slave port
  input  look_id_t lookup_id_i,
  output sel_t     lookup_sel_o,
  output logic     occupied_o,
  output logic     full_o,
  // push on AW admission
  input  logic     push_i,
  input  look_id_t push_id_i,
  input  sel_t     push_sel_i,
  // pop on B leaving the slave port
  input  logic     pop_i,
  input  look_id_t pop_id_i
);

  // open write count per tracked id
  logic [NUM_IDS-1:0][CNT_W-1:0] cnt_q;
  // port of the writes that are open, only valid while count is nonzero
  sel_t [NUM_IDS-1:0]            sel_q;

  logic [NUM_IDS-1:0] push_en;
  logic [NUM_IDS-1:0] pop_en;
  logic [NUM_IDS-1:0] cnt_full;

  // one-hot enables from the ids
  assign push_en = push_i ? (NUM_IDS'(1) << push_id_i) : '0;
  assign pop_en  = pop_i  ? (NUM_IDS'(1) << pop_id_i)  : '0;

  // ----------------------------------------
  // lookup and flags
  // ----------------------------------------
  assign lookup_sel_o = sel_q[lookup_id_i];
  assign occupied_o   = (cnt_q[lookup_id_i] != '0);

  always_comb begin
    for (int unsigned i = 0; i < NUM_IDS; i++) begin
      cnt_full[i] = (cnt_q[i] == CNT_W'(MAX_TRANS));
    end
  end

  assign full_o = |cnt_full;

  // ----------------------------------------
  // counters
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NUM_IDS; i++) begin
        // push alone counts up, pop alone counts down
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + CNT_W'(1);
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - CNT_W'(1);
        end
      end
    end
  end

  // select store, a later push with the same id carries the same port
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < NUM_IDS; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

  // a B at the slave port must belong to a write that was pushed before
  assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> (cnt_q[pop_id_i] != '0))
    else $error("id table pop on empty id %h", pop_id_i);

endmodule

//--- demux_pkg.sv
/*
  shared sizes, channel structs and types of the write demux
  NUM_PORTS must fit in SEL_W bits and MAX_TRANS must be a power of two
  only the LOOK_BITS low bits of an ID are tracked for ordering
  CNT_W must be able to hold MAX_TRANS
*/
package demux_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  // master ports and the select that picks one
  localparam int unsigned NUM_PORTS = 3;
  localparam int unsigned SEL_W     = 2;

  // axi id and the low bits used for ordering
  localparam int unsigned ID_W      = 4;
  localparam int unsigned LOOK_BITS = 2;
  localparam int unsigned NUM_IDS   = 2 ** LOOK_BITS;

  // open writes per id, also the depth of the W route FIFO
  localparam int unsigned MAX_TRANS = 4;
  localparam int unsigned CNT_W     = 3;
  localparam int unsigned PTR_W     = $clog2(MAX_TRANS);

  // payload widths
  localparam int unsigned ADDR_W    = 16;
  localparam int unsigned DATA_W    = 16;
  // burst length is beats minus one
  localparam int unsigned LEN_W     = 4;
  localparam int unsigned RESP_W    = 2;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [SEL_W-1:0]     sel_t;
  typedef logic [LOOK_BITS-1:0] look_id_t;

  // write address channel, 24 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } aw_chan_t;

  // write data channel, 17 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } w_chan_t;

  // write response channel, 6 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
  } b_chan_t;

  // AW control: idle means free to check, locked means valid is held
  typedef enum logic {
    AW_IDLE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_state_e;

endpackage

//--- demux_top.sv
/*
  write-path demux, one slave port to NUM_PORTS master ports
  AW and W are combinational paths, W waits one cycle after its AW
  B responses keep per-ID order through the ID table
*/
`timescale 1ns/1ps

module demux_top
  import demux_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  // slave port
  input  aw_chan_t                  slv_aw_i,
  input  sel_t                      slv_aw_sel_i,
  input  logic                      slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  input  w_chan_t                   slv_w_i,
  input  logic                      slv_w_valid_i,
  output logic                      slv_w_ready_o,
  output b_chan_t                   slv_b_o,
  output logic                      slv_b_valid_o,
  input  logic                      slv_b_ready_i,
  // master ports
  output aw_chan_t [NUM_PORTS-1:0]  mst_aw_o,
  output logic     [NUM_PORTS-1:0]  mst_aw_valid_o,
  input  logic     [NUM_PORTS-1:0]  mst_aw_ready_i,
  output w_chan_t  [NUM_PORTS-1:0]  mst_w_o,
  output logic     [NUM_PORTS-1:0]  mst_w_valid_o,
  input  logic     [NUM_PORTS-1:0]  mst_w_ready_i,
  input  b_chan_t  [NUM_PORTS-1:0]  mst_b_i,
  input  logic     [NUM_PORTS-1:0]  mst_b_valid_i,
  output logic     [NUM_PORTS-1:0]  mst_b_ready_o
);

  // id table
  logic id_occupied;
  logic id_full;
  sel_t id_lookup_sel;
  // route FIFO
  logic fifo_full;
  logic fifo_empty;
  sel_t fifo_sel;
  logic fifo_pop;
  // AW admission push
  logic aw_push;

  demux_aw_ctrl u_aw_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .slv_aw_i        (slv_aw_i),
    .slv_aw_sel_i    (slv_aw_sel_i),
    .slv_aw_valid_i  (slv_aw_valid_i),
    .slv_aw_ready_o  (slv_aw_ready_o),
    .slv_w_i         (slv_w_i),
    .slv_w_valid_i   (slv_w_valid_i),
    .slv_w_ready_o   (slv_w_ready_o),
    .mst_aw_o        (mst_aw_o),
    .mst_aw_valid_o  (mst_aw_valid_o),
    .mst_aw_ready_i  (mst_aw_ready_i),
    .mst_w_o         (mst_w_o),
    .mst_w_valid_o   (mst_w_valid_o),
    .mst_w_ready_i   (mst_w_ready_i),
    .id_occupied_i   (id_occupied),
    .id_full_i       (id_full),
    .id_lookup_sel_i (id_lookup_sel),
    .fifo_full_i     (fifo_full),
    .fifo_empty_i    (fifo_empty),
    .fifo_sel_i      (fifo_sel),
    .push_o          (aw_push),
    .fifo_pop_o      (fifo_pop)
  );

  // popped when a B leaves the slave port
  demux_id_table u_id_table (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lookup_id_i  (slv_aw_i.id[LOOK_BITS-1:0]),
    .lookup_sel_o (id_lookup_sel),
    .occupied_o   (id_occupied),
    .full_o       (id_full),
    .push_i       (aw_push),
    .push_id_i    (slv_aw_i.id[LOOK_BITS-1:0]),
    .push_sel_i   (slv_aw_sel_i),
    .pop_i        (slv_b_valid_o & slv_b_ready_i),
    .pop_id_i     (slv_b_o.id[LOOK_BITS-1:0])
  );

  demux_w_route_fifo u_w_route_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (aw_push),
    .sel_i   (slv_aw_sel_i),
    .pop_i   (fifo_pop),
    .sel_o   (fifo_sel),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  demux_b_arb u_b_arb (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i)
  );

endmodule

//--- demux_w_route_fifo.sv
/*
  FIFO of port selects that steers W bursts in AW order
  not fall-through, a pushed select is visible on sel_o one cycle later
  depth is MAX_TRANS and must be a power of two
*/
`timescale 1ns/1ps

module demux_w_route_fifo
  import demux_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  // write side, from AW admission
  input  logic push_i,
  input  sel_t sel_i,
  // read side, popped on the last W beat
  input  logic pop_i,
  output sel_t sel_o,
  output logic empty_o,
  output logic full_o
);

  // storage
  sel_t [MAX_TRANS-1:0] mem_q;

  // pointers wrap on their own since depth is a power of two
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // fill level, one bit wider to tell full from empty
  logic [PTR_W:0]   usage_q;

  logic do_push;
  logic do_pop;

  assign empty_o = (usage_q == '0);
  assign full_o  = (usage_q == (PTR_W + 1)'(MAX_TRANS));
  assign sel_o   = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // ----------------------------------------
  // pointers and fill level
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      // simultaneous push and pop keep the level
      if (do_push && !do_pop) begin
        usage_q <= usage_q + (PTR_W + 1)'(1);
      end else if (do_pop && !do_push) begin
        usage_q <= usage_q - (PTR_W + 1)'(1);
      end
    end
  end

  // data written at the write pointer
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= sel_i;
    end
  end

  // AW admission checks full, W steering checks empty
  assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_o))
    else $error("w route fifo push while full, sel %h", sel_i);

  assert property (@(posedge clk_i) disable iff (rst_i) !(pop_i && empty_o))
    else $error("w route fifo pop while empty");

endmodule

//--- tb_clk_gen.sv
/*
  testbench clock and reset source
  8 ns period, reset high for 8 rising edges and released 1 ns after the edge
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int unsigned HALF_PERIOD = 4;
  localparam int unsigned RST_CYCLES  = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release lines up with the input drive delay
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

//--- tb_demux.sv
/*
  testbench for demux_top with stimulus and expected ports from demux_golden.txt
  W data of a write is {seed, beat} and AW addr is {seed, write index}
  master ports are modeled with random ready stalls and B resp equal to the port number
  run from the project root so the data file is found
*/
`timescale 1ns/1ps

module tb_demux
  import demux_pkg::*;
;

  localparam int unsigned MAX_WR  = 32;
  localparam int unsigned TIMEOUT = 1000;

  logic clk;
  logic rst;

  // DUT ports
  aw_chan_t                  slv_aw_i;
  sel_t                      slv_aw_sel_i;
  logic                      slv_aw_valid_i;
  logic                      slv_aw_ready_o;
  w_chan_t                   slv_w_i;
  logic                      slv_w_valid_i;
  logic                      slv_w_ready_o;
  b_chan_t                   slv_b_o;
  logic                      slv_b_valid_o;
  logic                      slv_b_ready_i;
  aw_chan_t [NUM_PORTS-1:0]  mst_aw_o;
  logic     [NUM_PORTS-1:0]  mst_aw_valid_o;
  logic     [NUM_PORTS-1:0]  mst_aw_ready_i;
  w_chan_t  [NUM_PORTS-1:0]  mst_w_o;
  logic     [NUM_PORTS-1:0]  mst_w_valid_o;
  logic     [NUM_PORTS-1:0]  mst_w_ready_i;
  b_chan_t  [NUM_PORTS-1:0]  mst_b_i;
  logic     [NUM_PORTS-1:0]  mst_b_valid_i;
  logic     [NUM_PORTS-1:0]  mst_b_ready_o;

  // golden writes
  int unsigned      n_wr;
  logic [ID_W-1:0]  wr_id   [MAX_WR];
  sel_t             wr_sel  [MAX_WR];
  logic [LEN_W-1:0] wr_len  [MAX_WR];
  logic [7:0]       wr_seed [MAX_WR];
  sel_t             wr_exp  [MAX_WR];

  // writes of each master port in AW order
  int unsigned port_wr [NUM_PORTS][MAX_WR];
  int unsigned port_n  [NUM_PORTS];

  // master model progress per port
  int unsigned aw_acc [NUM_PORTS];
  int unsigned w_done [NUM_PORTS];
  int unsigned w_beat [NUM_PORTS];
  int unsigned b_sent [NUM_PORTS];
  int unsigned aw_total;
  int unsigned b_total;

  // open writes per low id as seen at the ports
  int unsigned open_cnt  [NUM_IDS];
  int unsigned open_port [NUM_IDS];

  // last cycle's stalled AW per port
  logic     [NUM_PORTS-1:0] aw_stall_q;
  aw_chan_t [NUM_PORTS-1:0] aw_hold_q;

  int unsigned err_cnt;
  int unsigned fail_cnt;
  logic        stop_run;
  int          seed = 56;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  demux_top uut (
    .clk_i          (clk),
    .rst_i          (rst),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_sel_i   (slv_aw_sel_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_i        (slv_w_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_b_o        (slv_b_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_i        (mst_b_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_o  (mst_b_ready_o)
  );

  // ----------------------------------------
  // expected payloads
  // ----------------------------------------
  function automatic aw_chan_t expected_aw(input int unsigned k);
    aw_chan_t aw;
    aw.id   = wr_id[k];
    aw.addr = {wr_seed[k], 8'(k)};
    aw.len  = wr_len[k];
    return aw;
  endfunction

  function automatic w_chan_t expected_w(input int unsigned k, input int unsigned beat);
    w_chan_t w;
    w.data = {wr_seed[k], 8'(beat)};
    w.last = (beat == wr_len[k]);
    return w;
  endfunction

  task automatic note_timeout(input string what);
    fail_cnt++;
    stop_run = 1'b1;
    $display("timeout: %s", what);
  endtask

  task automatic load_golden();
    int         fd;
    int         rc;
    string      line;
    logic [7:0] f_id;
    logic [7:0] f_sel;
    logic [7:0] f_len;
    logic [7:0] f_seed;
    logic [7:0] f_exp;
    n_wr = 0;
    fd = $fopen("demux_golden.txt", "r");
    if (fd == 0) begin
      fail_cnt++;
      stop_run = 1'b1;
      $display("could not open demux_golden.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // comment and empty lines skipped
      if (rc > 0 && line.len() > 1 && line[0] != "#") begin
        rc = $sscanf(line, "%h %h %h %h %h", f_id, f_sel, f_len, f_seed, f_exp);
        if (rc == 5 && n_wr < MAX_WR && f_exp < NUM_PORTS) begin
          wr_id[n_wr]   = f_id[ID_W-1:0];
          wr_sel[n_wr]  = f_sel[SEL_W-1:0];
          wr_len[n_wr]  = f_len[LEN_W-1:0];
          wr_seed[n_wr] = f_seed;
          wr_exp[n_wr]  = f_exp[SEL_W-1:0];
          port_wr[f_exp][port_n[f_exp]] = n_wr;
          port_n[f_exp]++;
          n_wr++;
        end
      end
    end
    $fclose(fd);
    if (n_wr == 0) begin
      fail_cnt++;
      stop_run = 1'b1;
      $display("no writes found in demux_golden.txt");
    end
  endtask

  // ----------------------------------------
  // slave side drivers
  // ----------------------------------------
  // AW valid stays high until the handshake
  task automatic send_aw(input int unsigned k);
    int unsigned waited;
    waited         = 0;
    slv_aw_i       = expected_aw(k);
    slv_aw_sel_i   = wr_sel[k];
    slv_aw_valid_i = 1'b1;
    @(posedge clk);
    while (!slv_aw_ready_o && !stop_run) begin
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout($sformatf("AW of write %0d never accepted", k));
      end
      @(posedge clk);
    end
    #1;
    slv_aw_valid_i = 1'b0;
  endtask

  task automatic send_w(input int unsigned k);
    int unsigned waited;
    for (int unsigned beat = 0; beat <= wr_len[k] && !stop_run; beat++) begin
      waited        = 0;
      slv_w_i       = expected_w(k, beat);
      slv_w_valid_i = 1'b1;
      @(posedge clk);
      while (!slv_w_ready_o && !stop_run) begin
        waited++;
        if (waited > TIMEOUT) begin
          note_timeout($sformatf("W beat %0d of write %0d never accepted", beat, k));
        end
        @(posedge clk);
      end
      #1;
    end
    slv_w_valid_i = 1'b0;
  endtask

  // ----------------------------------------
  // master port models and checks
  // ----------------------------------------
  always @(posedge clk) begin : port_models
    int unsigned          k;
    int unsigned          lid;
    int unsigned          n_b;
    int unsigned          b_k;
    b_chan_t              exp_b;
    logic [NUM_PORTS-1:0] b_hs;
    if (!rst) begin
      n_b  = 0;
      b_k  = 0;
      b_hs = '0;
      assert ($onehot0(mst_aw_valid_o)) else begin
        fail_cnt++;
        $display("AW offered on more than one master port at once");
      end
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        // a stalled AW must come back unchanged
        if (aw_stall_q[p]) begin
          assert (mst_aw_valid_o[p] && mst_aw_o[p] == aw_hold_q[p]) else begin
            err_cnt++;
            $display("[ERROR] mst_aw_o[%0d] held %h valid %h, expected %h valid 1",
                     p, mst_aw_o[p], mst_aw_valid_o[p], aw_hold_q[p]);
          end
        end
        // same low id may not be open at another port
        if (mst_aw_valid_o[p]) begin
          lid = mst_aw_o[p].id[LOOK_BITS-1:0];
          assert (open_cnt[lid] == 0 || open_port[lid] == p) else begin
            fail_cnt++;
            $display("AW id %h reached port %0d while the same low id is open at port %0d",
                     mst_aw_o[p].id, p, open_port[lid]);
          end
        end
        aw_stall_q[p] = mst_aw_valid_o[p] && !mst_aw_ready_i[p];
        aw_hold_q[p]  = mst_aw_o[p];
        if (mst_aw_valid_o[p] && mst_aw_ready_i[p]) begin
          k = aw_total;
          assert (k < n_wr && sel_t'(p) == wr_exp[k]) else begin
            err_cnt++;
            $display("[ERROR] mst_aw_valid_o port got %h expected %h", p, wr_exp[k]);
          end
          assert (mst_aw_o[p] == expected_aw(k)) else begin
            err_cnt++;
            $display("[ERROR] mst_aw_o[%0d] got %h expected %h", p, mst_aw_o[p], expected_aw(k));
          end
          lid = mst_aw_o[p].id[LOOK_BITS-1:0];
          open_cnt[lid]++;
          open_port[lid] = p;
          aw_acc[p]++;
          aw_total++;
        end
        // W beats follow the writes of this port in order
        if (mst_w_valid_o[p] && mst_w_ready_i[p]) begin
          assert (w_done[p] < port_n[p]) else begin
            fail_cnt++;
            $display("W beat at port %0d with no write routed there", p);
          end
          if (w_done[p] < port_n[p]) begin
            k = port_wr[p][w_done[p]];
            assert (mst_w_o[p] == expected_w(k, w_beat[p])) else begin
              err_cnt++;
              $display("[ERROR] mst_w_o[%0d] got %h expected %h",
                       p, mst_w_o[p], expected_w(k, w_beat[p]));
            end
            if (w_beat[p] == wr_len[k]) begin
              w_beat[p] = 0;
              w_done[p]++;
            end else begin
              w_beat[p]++;
            end
          end
        end
        if (mst_b_valid_i[p] && mst_b_ready_o[p]) begin
          b_hs[p] = 1'b1;
          b_k     = p;
          n_b++;
          b_sent[p]++;
        end
      end
      // slave B must match the master B taken in the same cycle
      if (slv_b_valid_o && slv_b_ready_i) begin
        assert (n_b == 1) else begin
          fail_cnt++;
          $display("slave B transfer without exactly one master B transfer");
        end
        if (n_b == 1) begin
          k          = port_wr[b_k][b_sent[b_k] - 1];
          exp_b.id   = wr_id[k];
          exp_b.resp = RESP_W'(b_k);
          assert (slv_b_o == exp_b) else begin
            err_cnt++;
            $display("[ERROR] slv_b_o got %h expected %h", slv_b_o, exp_b);
          end
        end
        lid = slv_b_o.id[LOOK_BITS-1:0];
        assert (open_cnt[lid] != 0) else begin
          fail_cnt++;
          $display("slave B with id %h has no open write", slv_b_o.id);
        end
        if (open_cnt[lid] != 0) begin
          open_cnt[lid]--;
        end
        b_total++;
      end else begin
        assert (n_b == 0) else begin
          fail_cnt++;
          $display("master B taken without a slave B transfer");
        end
      end

      // new ready and B values shortly after the edge
      #1;
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        mst_aw_ready_i[p] = (($random(seed) & 3) != 0);
        mst_w_ready_i[p]  = (($random(seed) & 3) != 0);
        // B offered only after both AW and last W beat and held until taken
        if (!mst_b_valid_i[p] || b_hs[p]) begin
          mst_b_valid_i[p] = 1'b0;
          if (b_sent[p] < aw_acc[p] && b_sent[p] < w_done[p] &&
              (($random(seed) & 1) != 0)) begin
            k                = port_wr[p][b_sent[p]];
            mst_b_i[p].id    = wr_id[k];
            mst_b_i[p].resp  = RESP_W'(p);
            mst_b_valid_i[p] = 1'b1;
          end
        end
      end
      slv_b_ready_i = (($random(seed) & 3) != 0);
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    int unsigned waited;
    slv_aw_i       = '0;
    slv_aw_sel_i   = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_aw_ready_i = '0;
    mst_w_ready_i  = '0;
    mst_b_i        = '0;
    mst_b_valid_i  = '0;
    aw_stall_q     = '0;
    aw_hold_q      = '0;
    err_cnt        = 0;
    fail_cnt       = 0;
    stop_run       = 1'b0;
    load_golden();

    waited = 0;
    @(negedge clk);
    while (rst && !stop_run) begin
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("reset never released");
      end
      @(negedge clk);
    end
    // idle after reset and before any stimulus
    assert (mst_aw_valid_o == '0 && mst_w_valid_o == '0 && !slv_b_valid_o) else begin
      err_cnt++;
      $display("[ERROR] after reset mst_aw_valid_o %h mst_w_valid_o %h slv_b_valid_o %h",
               mst_aw_valid_o, mst_w_valid_o, slv_b_valid_o);
    end

    @(posedge clk);
    #1;
    fork
      for (int unsigned k = 0; k < n_wr && !stop_run; k++) begin
        send_aw(k);
      end
      for (int unsigned k = 0; k < n_wr && !stop_run; k++) begin
        send_w(k);
      end
    join

    waited = 0;
    while (b_total < n_wr && !stop_run) begin
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("not every write got its B response");
      end
      @(negedge clk);
    end
    assert (aw_total == n_wr) else begin
      err_cnt++;
      $display("[ERROR] aw_total got %h expected %h", aw_total, n_wr);
    end
    assert (b_total == n_wr) else begin
      err_cnt++;
      $display("[ERROR] b_total got %h expected %h", b_total, n_wr);
    end

    $display("%0d value errors, %0d other failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- vlog.f
demux_pkg.sv
demux_id_table.sv
demux_w_route_fifo.sv
demux_aw_ctrl.sv
demux_b_arb.sv
demux_top.sv
tb_clk_gen.sv
tb_demux.sv
